/* bcfg_golden.txt */
# columns: command f1 f2 f3, all hex; RD/SRD addr 0 expect; WR/BW addr data 0
# PIN io1_pins io2_pins oe_word; DRV io1_in io2_in 0; SMP chan time busy_cycles; RST 0 0 rdata
RD  0000 0 00010805
RD  0010 0 bad0add0
RD  00ff 0 bad0add0
PIN 0 0 0
WR  0001 a5a5a5a5 0
RD  0001 0 a5a5a5a5
WR  0002 00000003 0
WR  0003 12345678 0
WR  0004 000000ab 0
RD  0004 0 000000ab
WR  0005 00000902 0
RD  0005 0 00000902
PIN a500 12000078 902
WR  000a cafef00d 0
RD  000a 0 cafef00d
WR  0006 deadbeef 0
RD  0006 0 00000000
WR  0000 ffffffff 0
RD  0000 0 00010805
BWS 0 0 0
BW  0001 11112222 0
BW  000a 0badcafe 0
BW  0005 00001f10 0
RD  0001 0 a5a5a5a5
PIN a500 12000078 902
BWE 0 0 0
RD  000a 0 0badcafe
RD  0005 0 00001f10
PIN 300000000 ab12345678 1f10
DRV 2f0e1d2c3 8877665544 0
RD  0006 0 f0e1d2c3
RD  0007 0 00000002
RD  0009 0 00000088
SMP 3 12345678 3
SRD 00 0 00000003
SRD 01 0 12345678
SRD 02 0 f0e1d2c3
SRD 03 0 00000000
DRV 155aa55aa 0 0
SMP 9 abcdef01 3
SRD 00 0 00000109
SRD 02 0 55aa55aa
SMP f 0 3
SRD 00 0 0000020f
RST 0 0 0
PIN 0 0 0
RD  0001 0 00000000
RD  000a 0 00000000
SRD 01 0 00000000

/* bcfg.f */
bcfg_pkg.sv
bcfg_addr_decode.sv
bcfg_io_regs.sv
bcfg_sampler.sv
bcfg_read_mux.sv
bcfg_top.sv
tb_bcfg.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the bcfg testbench with Verilator, run it, check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_bcfg -f bcfg.f -o tb_bcfg_sim
./obj_dir/tb_bcfg_sim | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "run failed, see $LOG"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
echo "run passed"

/* tb_bcfg.sv */
//##########################################################################
// testbench for the boot configuration register side
//   golden vector loader and bus command driver
//   compare tasks for register reads, sample reads, pins and counts
//   watchdog scaled to the number of golden lines
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_bcfg;

    localparam int CLK_PERIOD = 4;
    localparam int LINE_CYCLES = 40;    // time budget per golden line

    logic                           sysclk = 1'b0;
    logic                           reset;
    logic [3:0]                     wenid;
    bcfg_pkg::reg_addr_t            reg_raddr, reg_waddr;
    bcfg_pkg::quad_t                reg_wdata, reg_rdata, sample_rdata, timestamp;
    logic                           reg_wen, blk_wen, blk_wstart;
    logic                           sample_start, sample_busy;
    logic [bcfg_pkg::IO1_WIDTH-1:0] io1_in, io1_out, io1_oe;
    logic [bcfg_pkg::IO2_WIDTH-1:0] io2_in, io2_out, io2_oe;
    logic [3:0]                     sample_chan;
    logic [5:0]                     sample_raddr;

    string       cmd_q [$];
    logic [63:0] f1_q [$], f2_q [$], f3_q [$];
    int          n_cmds = 0;
    int          quad_errs = 0, samp_errs = 0, pin_errs = 0, misc_errs = 0;

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    bcfg_top uut (
        .sysclk       (sysclk),
        .reset        (reset),
        .wenid        (wenid),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .blk_wen      (blk_wen),
        .blk_wstart   (blk_wstart),
        .reg_rdata    (reg_rdata),
        .io1_in       (io1_in),
        .io1_out      (io1_out),
        .io1_oe       (io1_oe),
        .io2_in       (io2_in),
        .io2_out      (io2_out),
        .io2_oe       (io2_oe),
        .sample_start (sample_start),
        .sample_chan  (sample_chan),
        .sample_raddr (sample_raddr),
        .sample_rdata (sample_rdata),
        .sample_busy  (sample_busy),
        .timestamp    (timestamp)
    );

    task automatic check_quad(input bcfg_pkg::quad_t got, input bcfg_pkg::quad_t exp,
                              input string what);
        if (got !== exp) begin
            quad_errs++;
            $display("error at %0d ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sample(input bcfg_pkg::quad_t got, input bcfg_pkg::quad_t exp,
                                input string what);
        if (got !== exp) begin
            samp_errs++;
            $display("error at %0d ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    // pins against the expected state, oe groups spread over 8 pins each
    task automatic check_pins(input bcfg_pkg::io_state_t exp);
        bcfg_pkg::io_state_t            got;
        logic [bcfg_pkg::IO1_WIDTH-1:0] oe1_exp;
        logic [bcfg_pkg::IO2_WIDTH-1:0] oe2_exp;
        for (int i = 0; i < bcfg_pkg::IO1_WIDTH; i++)
            oe1_exp[i] = exp.io1_oe[i / 8];
        for (int i = 0; i < bcfg_pkg::IO2_WIDTH; i++)
            oe2_exp[i] = exp.io2_oe[i / 8];
        got.io1_out = io1_out;
        got.io2_out = io2_out;
        got.io1_oe  = {io1_oe[32], io1_oe[24], io1_oe[16], io1_oe[8], io1_oe[0]};
        got.io2_oe  = {io2_oe[32], io2_oe[24], io2_oe[16], io2_oe[8], io2_oe[0]};
        if (got !== exp || io1_oe !== oe1_exp || io2_oe !== oe2_exp) begin
            pin_errs++;
            $display("error at %0d ns: pins gave %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got !== exp) begin
            misc_errs++;
            $display("error at %0d ns: %s was %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic load_golden();
        int          fd;
        string       line, cmd;
        logic [63:0] a, b, c;
        fd = $fopen("bcfg_golden.txt", "r");
        if (fd == 0) begin
            n_cmds = -1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin     // skip blanks, comments
                    if ($sscanf(line, "%s %h %h %h", cmd, a, b, c) == 4) begin
                        cmd_q.push_back(cmd);
                        f1_q.push_back(a);
                        f2_q.push_back(b);
                        f3_q.push_back(c);
                    end else begin
                        misc_errs++;
                        $display("golden line could not be understood: %s", line);
                    end
                end
            end
            $fclose(fd);
            n_cmds = cmd_q.size();
        end
    endtask

    // called just after a rising edge, drives with nonblocking assignments
    task automatic run_cmd(input string cmd, input logic [63:0] f1, f2, f3);
        bcfg_pkg::io_state_t pins;
        int                  n;
        logic                b;
        case (cmd)
            "RD": begin
                reg_raddr <= f1[15:0];
                @(posedge sysclk);
                @(negedge sysclk);      // one cycle after the address
                check_quad(reg_rdata, f3[31:0], $sformatf("read of %h", f1[15:0]));
            end
            "SRD": begin
                sample_raddr <= f1[5:0];
                @(posedge sysclk);
                @(negedge sysclk);
                check_sample(sample_rdata, f3[31:0], $sformatf("sample read %0d", f1[5:0]));
            end
            "WR", "BW": begin           // staging depends only on block mode
                reg_waddr <= f1[15:0];
                reg_wdata <= f2[31:0];
                reg_wen   <= 1'b1;
                @(posedge sysclk);
                reg_wen   <= 1'b0;
            end
            "BWS": begin
                blk_wstart <= 1'b1;
                @(posedge sysclk);
                blk_wstart <= 1'b0;
            end
            "BWE": begin
                blk_wen <= 1'b1;
                @(posedge sysclk);
                blk_wen <= 1'b0;
            end
            "DRV": begin
                io1_in <= f1[bcfg_pkg::IO1_WIDTH-1:0];
                io2_in <= f2[bcfg_pkg::IO2_WIDTH-1:0];
                repeat (2) @(posedge sysclk);   // synchronizer depth
            end
            "PIN": begin
                pins.io1_out = f1[bcfg_pkg::IO1_WIDTH-1:0];
                pins.io2_out = f2[bcfg_pkg::IO2_WIDTH-1:0];
                pins.io1_oe  = f3[4:0];
                pins.io2_oe  = f3[12:8];
                @(negedge sysclk);
                check_pins(pins);
            end
            "SMP": begin
                sample_chan  <= f1[3:0];
                timestamp    <= f2[31:0];
                sample_start <= 1'b1;
                @(posedge sysclk);      // capture begins here
                sample_chan  <= ~f1[3:0];   // start held a 2nd cycle, busy ignores it
                timestamp    <= ~f2[31:0];
                n = 0;
                do begin
                    @(negedge sysclk);
                    b = sample_busy;
                    if (b)
                        n++;
                    @(posedge sysclk);
                    sample_start <= 1'b0;
                end while (b && n < 64);
                check_count(n, int'(f3), "sample_busy cycles");
            end
            "RST": begin
                reg_raddr    <= bcfg_pkg::ADDR_STATUS;  // status is never zero
                sample_start <= 1'b1;                   // reset hits a running capture
                @(posedge sysclk);
                sample_start <= 1'b0;
                reset        <= 1'b1;
                @(posedge sysclk);      // first reset edge
                @(negedge sysclk);
                check_count(int'(sample_busy), 0, "sample_busy in reset");
                repeat (4) @(posedge sysclk);
                reset <= 1'b0;
                @(negedge sysclk);
                check_quad(reg_rdata, f3[31:0], "reg_rdata after reset");
                check_sample(sample_rdata, f3[31:0], "sample_rdata after reset");
            end
            default: begin
                misc_errs++;
                $display("unknown golden command %s", cmd);
            end
        endcase
    endtask

    initial begin
        reset        <= 1'b1;
        wenid        <= 4'b1010;    // board id 5
        reg_raddr    <= '0;
        reg_waddr    <= '0;
        reg_wdata    <= '0;
        reg_wen      <= 1'b0;
        blk_wen      <= 1'b0;
        blk_wstart   <= 1'b0;
        io1_in       <= '0;
        io2_in       <= '0;
        sample_start <= 1'b0;
        sample_chan  <= '0;
        sample_raddr <= '0;
        timestamp    <= '0;
        void'($urandom(26));
        load_golden();
        if (n_cmds < 0) begin
            $display("the golden file bcfg_golden.txt is missing or cannot be read");
            $display("SIMULATION FAILED");
        end else begin
            repeat (5) @(posedge sysclk);
            reset <= 1'b0;
            for (int i = 0; i < n_cmds; i++) begin
                repeat ($urandom % 3) @(posedge sysclk);   // random idle gap
                @(posedge sysclk);
                run_cmd(cmd_q[i], f1_q[i], f2_q[i], f3_q[i]);
            end
            @(posedge sysclk);
            $display("errors: %0d reg read, %0d sample read, %0d pin, %0d other",
                     quad_errs, samp_errs, pin_errs, misc_errs);
            if (quad_errs + samp_errs + pin_errs + misc_errs == 0)
                $display("SIMULATION PASSED");
            else
                $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (n_cmds > 0);
        #((n_cmds * LINE_CYCLES + 10) * CLK_PERIOD);
        $display("the run timed out before all golden lines were done");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bcfg_top.sv */
//##########################################################################
// top level of the boot configuration register side
//   board id from the rotary switch
//   decoder, io registers, sampler and read return
//   per-pin oe expansion and output masking
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module bcfg_top (
    input  logic                           sysclk,
    input  logic                           reset,
    input  logic [3:0]                     wenid,          // rotary switch, active low
    input  bcfg_pkg::reg_addr_t            reg_raddr,
    input  bcfg_pkg::reg_addr_t            reg_waddr,
    input  bcfg_pkg::quad_t                reg_wdata,
    input  logic                           reg_wen,
    input  logic                           blk_wen,
    input  logic                           blk_wstart,
    output bcfg_pkg::quad_t                reg_rdata,
    input  logic [bcfg_pkg::IO1_WIDTH-1:0] io1_in,
    output logic [bcfg_pkg::IO1_WIDTH-1:0] io1_out,
    output logic [bcfg_pkg::IO1_WIDTH-1:0] io1_oe,
    input  logic [bcfg_pkg::IO2_WIDTH-1:0] io2_in,
    output logic [bcfg_pkg::IO2_WIDTH-1:0] io2_out,
    output logic [bcfg_pkg::IO2_WIDTH-1:0] io2_oe,
    input  logic                           sample_start,
    input  logic [3:0]                     sample_chan,
    input  logic [5:0]                     sample_raddr,
    output bcfg_pkg::quad_t                sample_rdata,
    output logic                           sample_busy,
    input  bcfg_pkg::quad_t                timestamp
);

    logic [3:0]            board_id;
    bcfg_pkg::reg_sel_e    rd_sel;
    bcfg_pkg::wr_cmd_t     wr_cmd;
    bcfg_pkg::io_state_t   io_state;
    bcfg_pkg::io_in_t      io_in;
    bcfg_pkg::quad_t       scratch;
    bcfg_pkg::samp_state_e samp_state;     // debug view of the sampler FSM

    assign board_id = ~wenid;

    bcfg_addr_decode u_decode (
        .sysclk     (sysclk),
        .reset      (reset),
        .reg_raddr  (reg_raddr),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_wen    (reg_wen),
        .blk_wen    (blk_wen),
        .blk_wstart (blk_wstart),
        .rd_sel     (rd_sel),
        .wr_cmd     (wr_cmd)
    );

    bcfg_io_regs u_io_regs (
        .sysclk   (sysclk),
        .reset    (reset),
        .wr_cmd   (wr_cmd),
        .blk_wen  (blk_wen),
        .io1_in   (io1_in),
        .io2_in   (io2_in),
        .io_state (io_state),
        .io_in    (io_in),
        .scratch  (scratch)
    );

    bcfg_sampler u_sampler (
        .sysclk       (sysclk),
        .reset        (reset),
        .sample_start (sample_start),
        .sample_chan  (sample_chan),
        .timestamp    (timestamp),
        .io_in        (io_in),
        .sample_raddr (sample_raddr),
        .sample_busy  (sample_busy),
        .sample_rdata (sample_rdata),
        .samp_state   (samp_state)
    );

    bcfg_read_mux u_read_mux (
        .sysclk    (sysclk),
        .reset     (reset),
        .rd_sel    (rd_sel),
        .board_id  (board_id),
        .io_state  (io_state),
        .io_in     (io_in),
        .scratch   (scratch),
        .reg_rdata (reg_rdata)
    );

    // one oe bit per 8 pins, last io1 group has only pins 33..32
    always_comb begin
        for (int i = 0; i < bcfg_pkg::IO1_WIDTH; i++)
            io1_oe[i] = io_state.io1_oe[i / 8];
        for (int i = 0; i < bcfg_pkg::IO2_WIDTH; i++)
            io2_oe[i] = io_state.io2_oe[i / 8];
    end

    assign io1_out = io_state.io1_out & io1_oe;    // released pins read as zero
    assign io2_out = io_state.io2_out & io2_oe;

endmodule

`default_nettype wire

/* bcfg_read_mux.sv */
//##########################################################################
// register read return
//   status word from board id and firmware version
//   io output, oe and input quadlets, scratch
//   registered reg_rdata, one cycle after the read address
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module bcfg_read_mux (
    input  logic                sysclk,
    input  logic                reset,
    input  bcfg_pkg::reg_sel_e  rd_sel,
    input  logic [3:0]          board_id,
    input  bcfg_pkg::io_state_t io_state,
    input  bcfg_pkg::io_in_t    io_in,
    input  bcfg_pkg::quad_t     scratch,
    output bcfg_pkg::quad_t     reg_rdata
);

    bcfg_pkg::quad_t status_word, oe_word, rd_next;

    assign status_word = {bcfg_pkg::FW_VERSION[31:8], 4'h0, board_id};
    assign oe_word     = {19'd0, io_state.io2_oe, 3'd0, io_state.io1_oe};

    always_comb begin
        case (rd_sel)
            bcfg_pkg::SEL_STATUS:     rd_next = status_word;
            bcfg_pkg::SEL_IO1_OUT_LO: rd_next = io_state.io1_out[31:0];
            bcfg_pkg::SEL_IO1_OUT_HI: rd_next = {30'd0, io_state.io1_out[33:32]};
            bcfg_pkg::SEL_IO2_OUT_LO: rd_next = io_state.io2_out[31:0];
            bcfg_pkg::SEL_IO2_OUT_HI: rd_next = {24'd0, io_state.io2_out[39:32]};
            bcfg_pkg::SEL_IO_OE:      rd_next = oe_word;
            bcfg_pkg::SEL_IO1_IN_LO:  rd_next = io_in.io1_in[31:0];   // synchronized copy
            bcfg_pkg::SEL_IO1_IN_HI:  rd_next = {30'd0, io_in.io1_in[33:32]};
            bcfg_pkg::SEL_IO2_IN_LO:  rd_next = io_in.io2_in[31:0];
            bcfg_pkg::SEL_IO2_IN_HI:  rd_next = {24'd0, io_in.io2_in[39:32]};
            bcfg_pkg::SEL_SCRATCH:    rd_next = scratch;
            default:                  rd_next = bcfg_pkg::BAD_ADDR_DATA;
        endcase
    end

    // no read side effects, just a register stage
    always_ff @(posedge sysclk) begin
        if (reset)
            reg_rdata <= '0;
        else
            reg_rdata <= rd_next;
    end

endmodule

`default_nettype wire

/* bcfg_sampler.sv */
//##########################################################################
// broadcast block sampler
//   FSM started by sample_start, busy for one cycle per quadlet
//   sequence counter, latched channel, timestamp and io1 snapshot
//   quadlet buffer with registered read port
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module bcfg_sampler (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  sample_start,
    input  logic [3:0]            sample_chan,
    input  bcfg_pkg::quad_t       timestamp,
    input  bcfg_pkg::io_in_t      io_in,
    input  logic [5:0]            sample_raddr,
    output logic                  sample_busy,
    output bcfg_pkg::quad_t       sample_rdata,
    output bcfg_pkg::samp_state_e samp_state
);

    localparam logic [1:0] LAST_IDX = 2'(bcfg_pkg::NUM_BC_READ_QUADS - 1);

    bcfg_pkg::samp_state_e state;
    bcfg_pkg::quad_t       buffer [bcfg_pkg::NUM_BC_READ_QUADS];
    bcfg_pkg::quad_t       ts_q, snap_q, wr_word;
    logic [23:0]           seq_num;     // bumps once per capture
    logic [3:0]            chan_q;
    logic [1:0]            widx;        // buffer write slot

    // quadlet for the current slot
    always_comb begin
        case (widx)
            2'd0:    wr_word = {seq_num, 4'h0, chan_q};
            2'd1:    wr_word = ts_q;
            default: wr_word = snap_q;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state   <= bcfg_pkg::S_IDLE;
            seq_num <= '0;
            chan_q  <= '0;
            ts_q    <= '0;
            snap_q  <= '0;
            widx    <= '0;
            for (int i = 0; i < bcfg_pkg::NUM_BC_READ_QUADS; i++)
                buffer[i] <= '0;   // sample reads are zero out of reset
        end else begin
            case (state)
                bcfg_pkg::S_CAPTURE: begin
                    buffer[widx] <= wr_word;
                    widx         <= widx + 2'd1;
                    if (widx == LAST_IDX) begin
                        state   <= bcfg_pkg::S_DONE;
                        seq_num <= seq_num + 24'd1;
                    end
                end
                default: begin              // idle or done, both accept a start
                    state <= bcfg_pkg::S_IDLE;
                    if (sample_start) begin
                        state  <= bcfg_pkg::S_CAPTURE;
                        chan_q <= sample_chan;
                        ts_q   <= timestamp;
                        snap_q <= io_in.io1_in[31:0];
                        widx   <= '0;
                    end
                end
            endcase
        end
    end

    // registered read, zero past the block
    always_ff @(posedge sysclk) begin
        if (reset)
            sample_rdata <= '0;
        else if (sample_raddr < 6'(bcfg_pkg::NUM_BC_READ_QUADS))
            sample_rdata <= buffer[sample_raddr[1:0]];
        else
            sample_rdata <= '0;
    end

    assign sample_busy = (state == bcfg_pkg::S_CAPTURE);   // start pulses ignored here
    assign samp_state  = state;

endmodule

`default_nettype wire

/* bcfg_io_regs.sv */
//##########################################################################
// io output and oe registers with block-write shadows
//   live and shadow io state, scratch register and its shadow
//   commit of all shadows at blk_wen
//   two-flop synchronizers on the io1 and io2 inputs
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module bcfg_io_regs (
    input  logic                               sysclk,
    input  logic                               reset,
    input  bcfg_pkg::wr_cmd_t                  wr_cmd,
    input  logic                               blk_wen,
    input  logic [bcfg_pkg::IO1_WIDTH-1:0]     io1_in,
    input  logic [bcfg_pkg::IO2_WIDTH-1:0]     io2_in,
    output bcfg_pkg::io_state_t                io_state,
    output bcfg_pkg::io_in_t                   io_in,
    output bcfg_pkg::quad_t                    scratch
);

    bcfg_pkg::io_state_t live, shadow;
    bcfg_pkg::quad_t     scr_live, scr_shadow;
    bcfg_pkg::io_in_t    sync_a, sync_b;   // metastability pair
    logic                wr_live, wr_shadow, wr_scr;

    // field update shared by the live and shadow copies
    function automatic bcfg_pkg::io_state_t upd_io(input bcfg_pkg::io_state_t s,
                                                   input bcfg_pkg::wr_cmd_t c);
        bcfg_pkg::io_state_t r;
        r = s;
        case (c.sel)
            bcfg_pkg::SEL_IO1_OUT_LO: r.io1_out[31:0]  = c.data;
            bcfg_pkg::SEL_IO1_OUT_HI: r.io1_out[33:32] = c.data[1:0];  // 2 pins only
            bcfg_pkg::SEL_IO2_OUT_LO: r.io2_out[31:0]  = c.data;
            bcfg_pkg::SEL_IO2_OUT_HI: r.io2_out[39:32] = c.data[7:0];
            bcfg_pkg::SEL_IO_OE: begin
                r.io1_oe = c.data[4:0];
                r.io2_oe = c.data[12:8];
            end
            default: ;                  // inputs, status, unmapped
        endcase
        return r;
    endfunction

    assign wr_live   = wr_cmd.wen && !wr_cmd.blk;
    // shadow tracks single writes as well, so a commit never brings back stale data
    assign wr_shadow = wr_cmd.wen && (wr_cmd.blk || !blk_wen);
    assign wr_scr    = (wr_cmd.sel == bcfg_pkg::SEL_SCRATCH);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            live       <= '0;
            shadow     <= '0;
            scr_live   <= '0;
            scr_shadow <= '0;
        end else begin
            if (blk_wen) begin              // commit wins over a single write
                live     <= shadow;
                scr_live <= scr_shadow;
            end else if (wr_live) begin
                live <= upd_io(live, wr_cmd);
                if (wr_scr)
                    scr_live <= wr_cmd.data;
            end
            if (wr_shadow) begin
                shadow <= upd_io(shadow, wr_cmd);
                if (wr_scr)
                    scr_shadow <= wr_cmd.data;
            end
        end
    end

    // pins in, two cycles to io_in
    always_ff @(posedge sysclk) begin
        if (reset) begin
            sync_a <= '0;
            sync_b <= '0;
        end else begin
            sync_a.io1_in <= io1_in;
            sync_a.io2_in <= io2_in;
            sync_b        <= sync_a;
        end
    end

    assign io_state = live;
    assign io_in    = sync_b;
    assign scratch  = scr_live;

endmodule

`default_nettype wire

/* bcfg_addr_decode.sv */
//##########################################################################
// address decoder for the quadlet register bus
//   read address to register select
//   write address, data and strobes to a write command
//   block-mode flag between blk_wstart and blk_wen
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module bcfg_addr_decode (
    input  logic                sysclk,
    input  logic                reset,
    input  bcfg_pkg::reg_addr_t reg_raddr,
    input  bcfg_pkg::reg_addr_t reg_waddr,
    input  bcfg_pkg::quad_t     reg_wdata,
    input  logic                reg_wen,
    input  logic                blk_wen,
    input  logic                blk_wstart,
    output bcfg_pkg::reg_sel_e  rd_sel,
    output bcfg_pkg::wr_cmd_t   wr_cmd
);

    logic blk_flag;     // inside a block write

    // same map for both sides, writes drop the read-only registers
    function automatic bcfg_pkg::reg_sel_e map_addr(input bcfg_pkg::reg_addr_t addr,
                                                     input logic wr);
        bcfg_pkg::reg_sel_e sel;
        case (addr)
            bcfg_pkg::ADDR_STATUS:     sel = wr ? bcfg_pkg::SEL_NONE : bcfg_pkg::SEL_STATUS;
            bcfg_pkg::ADDR_IO1_OUT_LO: sel = bcfg_pkg::SEL_IO1_OUT_LO;
            bcfg_pkg::ADDR_IO1_OUT_HI: sel = bcfg_pkg::SEL_IO1_OUT_HI;
            bcfg_pkg::ADDR_IO2_OUT_LO: sel = bcfg_pkg::SEL_IO2_OUT_LO;
            bcfg_pkg::ADDR_IO2_OUT_HI: sel = bcfg_pkg::SEL_IO2_OUT_HI;
            bcfg_pkg::ADDR_IO_OE:      sel = bcfg_pkg::SEL_IO_OE;
            bcfg_pkg::ADDR_IO1_IN_LO:  sel = wr ? bcfg_pkg::SEL_NONE : bcfg_pkg::SEL_IO1_IN_LO;
            bcfg_pkg::ADDR_IO1_IN_HI:  sel = wr ? bcfg_pkg::SEL_NONE : bcfg_pkg::SEL_IO1_IN_HI;
            bcfg_pkg::ADDR_IO2_IN_LO:  sel = wr ? bcfg_pkg::SEL_NONE : bcfg_pkg::SEL_IO2_IN_LO;
            bcfg_pkg::ADDR_IO2_IN_HI:  sel = wr ? bcfg_pkg::SEL_NONE : bcfg_pkg::SEL_IO2_IN_HI;
            bcfg_pkg::ADDR_SCRATCH:    sel = bcfg_pkg::SEL_SCRATCH;
            default:                   sel = bcfg_pkg::SEL_NONE;
        endcase
        return sel;
    endfunction

    // flag set by the start pulse, cleared by the commit
    always_ff @(posedge sysclk) begin
        if (reset)
            blk_flag <= 1'b0;
        else if (blk_wen)
            blk_flag <= 1'b0;
        else if (blk_wstart)
            blk_flag <= 1'b1;
    end

    assign rd_sel = map_addr(reg_raddr, 1'b0);

    always_comb begin
        wr_cmd.sel  = map_addr(reg_waddr, 1'b1);
        wr_cmd.data = reg_wdata;
        wr_cmd.wen  = reg_wen;
        wr_cmd.blk  = blk_flag | blk_wstart;   // a write alongside the start is staged too
    end

endmodule

`default_nettype wire

/* bcfg_pkg.sv */
//##########################################################################
// shared definitions for the boot configuration subsystem
//   quadlet and bus address types, firmware version, bad-address marker
//   sampler block sizes and io bank widths
//   register address map and decoded register selects
//   sampler FSM states, write command, io state and io input structs
//##########################################################################
`default_nettype none

package bcfg_pkg;

    typedef logic [31:0] quad_t;        // one bus quadlet
    typedef logic [15:0] reg_addr_t;    // quadlet address

    localparam quad_t FW_VERSION    = 32'h0001_0800;   // only 31..8 reach status
    localparam quad_t BAD_ADDR_DATA = 32'hBAD0_ADD0;

    // real-time block plus one leading sequence/channel quadlet
    localparam int NUM_RT_READ_QUADS = 2;
    localparam int NUM_BC_READ_QUADS = 1 + NUM_RT_READ_QUADS;

    localparam int IO1_WIDTH = 34;      // connector J1
    localparam int IO2_WIDTH = 40;      // connector J2

    // address map
    localparam reg_addr_t ADDR_STATUS     = 16'h0000;
    localparam reg_addr_t ADDR_IO1_OUT_LO = 16'h0001;
    localparam reg_addr_t ADDR_IO1_OUT_HI = 16'h0002;
    localparam reg_addr_t ADDR_IO2_OUT_LO = 16'h0003;
    localparam reg_addr_t ADDR_IO2_OUT_HI = 16'h0004;
    localparam reg_addr_t ADDR_IO_OE      = 16'h0005;  // io1 groups 4..0, io2 groups 12..8
    localparam reg_addr_t ADDR_IO1_IN_LO  = 16'h0006;  // inputs are read only
    localparam reg_addr_t ADDR_IO1_IN_HI  = 16'h0007;
    localparam reg_addr_t ADDR_IO2_IN_LO  = 16'h0008;
    localparam reg_addr_t ADDR_IO2_IN_HI  = 16'h0009;
    localparam reg_addr_t ADDR_SCRATCH    = 16'h000A;

    typedef enum logic [3:0] {
        SEL_STATUS,
        SEL_IO1_OUT_LO,
        SEL_IO1_OUT_HI,
        SEL_IO2_OUT_LO,
        SEL_IO2_OUT_HI,
        SEL_IO_OE,
        SEL_IO1_IN_LO,
        SEL_IO1_IN_HI,
        SEL_IO2_IN_LO,
        SEL_IO2_IN_HI,
        SEL_SCRATCH,
        SEL_NONE            // unmapped, or a write to a read-only register
    } reg_sel_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CAPTURE,          // one buffer quadlet per cycle
        S_DONE
    } samp_state_e;

    typedef struct packed {
        reg_sel_e sel;
        quad_t    data;
        logic     wen;
        logic     blk;      // staged, applied at blk_wen
    } wr_cmd_t;

    typedef struct packed {
        logic [IO1_WIDTH-1:0] io1_out;
        logic [IO2_WIDTH-1:0] io2_out;
        logic [4:0]           io1_oe;   // one bit per 8-pin group
        logic [4:0]           io2_oe;
    } io_state_t;

    typedef struct packed {
        logic [IO1_WIDTH-1:0] io1_in;
        logic [IO2_WIDTH-1:0] io2_in;
    } io_in_t;

endpackage

`default_nettype wire
